// File: axi_write_master.sv
`timescale 1ns/1ps
module axi_write_master import mcw_pkg::*; #(
  parameter int AXI_ID = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  wr_cmd_t               cmd,
  input  logic                  cmd_valid,
  input  logic                  beat_empty,
  input  logic [AXI_DATA_W-1:0] beat_data,
  input  logic                  aw_ready,
  input  logic                  w_ready,
  input  axi_b_t                b,
  input  logic                  b_valid,
  output logic                  cmd_take,
  output logic                  cmd_done,
  output logic                  beat_pop,
  output axi_aw_t               aw,
  output logic                  aw_valid,
  output axi_w_t                w,
  output logic                  w_valid,
  output logic                  b_ready,
  output logic                  wr_done,
  output logic                  wr_error
);
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_AW   = 3'd1;
  localparam logic [2:0] S_W    = 3'd2;
  localparam logic [2:0] S_B    = 3'd3;
  localparam logic [2:0] S_DONE = 3'd4;

  localparam logic [ADDR_W-1:0] BURST_STEP = ADDR_W'(MAX_BURST * BEAT_BYTES);  // 128 bytes

  logic [2:0]        state;
  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  left;         // beats not yet in a finished burst
  logic [LEN_W-1:0]  burst_beats;
  logic [LEN_W-1:0]  len_m1;
  logic [3:0]        beat_cnt;     // beats left in this burst minus one
  logic              err_q;
  logic              w_hs;

  assign burst_beats = (left > LEN_W'(MAX_BURST)) ? LEN_W'(MAX_BURST) : left;
  assign len_m1      = burst_beats - 1'b1;

  // ==================================================
  // channel outputs
  // ==================================================
  always_comb begin
    aw.id    = ID_W'(AXI_ID);
    aw.addr  = addr_q;
    aw.len   = len_m1[3:0];
    aw.size  = 3'($clog2(BEAT_BYTES));
    aw.burst = 2'b01;    // INCR
    aw.lock  = 2'b00;
    aw.cache = 4'b0011;
    aw.prot  = 3'b000;
    aw.qos   = 4'h0;
  end

  assign w.data = beat_data;
  assign w.strb = '1;
  assign w.last = (beat_cnt == 4'd0);

  assign aw_valid = (state == S_AW);
  assign w_valid  = (state == S_W) && !beat_empty;
  assign w_hs     = w_valid && w_ready;
  assign beat_pop = w_hs;
  assign b_ready  = (state == S_B);

  assign cmd_take = (state == S_IDLE) && cmd_valid;
  assign cmd_done = (state == S_DONE);
  assign wr_done  = (state == S_DONE);
  assign wr_error = (state == S_DONE) && err_q;

  // ==================================================
  // burst sequencing
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state    <= S_IDLE;
      left     <= '0;
      beat_cnt <= '0;
      err_q    <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid) begin
            left  <= cmd.beats;
            err_q <= 1'b0;
            state <= S_AW;
          end
        end
        S_AW: begin
          if (aw_ready) begin
            beat_cnt <= len_m1[3:0];
            state    <= S_W;
          end
        end
        S_W: begin
          if (w_hs) begin
            beat_cnt <= beat_cnt - 1'b1;
            if (w.last) begin
              left  <= left - burst_beats;
              state <= S_B;
            end
          end
        end
        S_B: begin
          if (b_valid) begin
            if (b.resp != 2'b00) err_q <= 1'b1;  // sticky for the command
            state <= (left == '0) ? S_DONE : S_AW;
          end
        end
        S_DONE:  state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take)                          addr_q <= cmd.addr;
    else if (state == S_W && w_hs && w.last) addr_q <= addr_q + BURST_STEP;
  end

endmodule

// File: chip_link.sv
`timescale 1ns/1ps
module chip_link import mcw_pkg::*; #(
  parameter int CAP_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             config_req,
  input  logic [BUS_W-1:0]                 spi_data,
  input  logic                             cmd_accept,
  input  logic                             cmd_reject,
  input  logic                             cmd_free,
  input  logic [LEN_W-1:0]                 words,
  input  logic [$clog2(CAP_DEPTH+1)-1:0]   cap_count,
  output logic                             spi_cs_n,
  output logic                             cfg_valid,
  output bus_word_u                        cfg,
  output logic                             cap_push,
  output logic [BUS_W-1:0]                 cap_data
);
  localparam int CNT_W = $clog2(CAP_DEPTH+1);

  localparam logic [2:0] S_IDLE   = 3'd0;
  localparam logic [2:0] S_CONFIG = 3'd1;
  localparam logic [2:0] S_DECODE = 3'd2;
  localparam logic [2:0] S_XFER   = 3'd3;
  localparam logic [2:0] S_DRAIN  = 3'd4;

  logic             req_s1;
  logic             req_s2;
  logic             req_s3;
  logic             req_rise;
  logic [2:0]       state;
  logic [LEN_W-1:0] remaining;   // selects still to issue
  logic             sel_d;       // word asked at last edge
  logic [CNT_W:0]   fill;
  logic             room;
  bus_word_u        bus_word;

  // ==================================================
  // request synchronizer
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
      req_s3 <= 1'b0;
    end else begin
      req_s1 <= config_req;
      req_s2 <= req_s1;
      req_s3 <= req_s2;  // edge detect only
    end
  end

  assign req_rise = req_s2 && !req_s3;

  // ==================================================
  // bus sampling
  // ==================================================
  assign bus_word = spi_data;

  // config word lands on the edge that leaves idle
  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_rise) cfg <= bus_word;
  end

  assign cfg_valid = (state == S_CONFIG) && cmd_free;
  assign cap_push  = sel_d;          // chip drives the word one cycle after select
  assign cap_data  = bus_word.raw;

  // fifo words plus the ones already asked for
  assign fill = (CNT_W+1)'(cap_count) + (CNT_W+1)'(sel_d) + (CNT_W+1)'(!spi_cs_n);
  assign room = fill < (CNT_W+1)'(CAP_DEPTH);

  // ==================================================
  // transfer FSM
  // ==================================================
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      state     <= S_IDLE;
      remaining <= '0;
      spi_cs_n  <= 1'b1;
      sel_d     <= 1'b0;
    end else begin
      sel_d    <= !spi_cs_n;
      spi_cs_n <= 1'b1;
      case (state)
        S_IDLE:   if (req_rise) state <= S_CONFIG;
        S_CONFIG: if (cmd_free) state <= S_DECODE;  // wait for previous command
        S_DECODE: begin
          if (cmd_accept) begin
            state     <= S_XFER;
            remaining <= words;
          end else if (cmd_reject) begin
            state <= S_IDLE;
          end
        end
        S_XFER: begin
          if (remaining == '0) begin
            state <= S_DRAIN;
          end else if (room) begin
            spi_cs_n  <= 1'b0;
            remaining <= remaining - 1'b1;
          end
        end
        S_DRAIN:  if (spi_cs_n && !sel_d) state <= S_IDLE;  // last push done
        default:  state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: mcw_pkg.sv
package mcw_pkg;

  // ==================================================
  // widths
  // ==================================================
  localparam int BUS_W      = 96;
  localparam int AXI_DATA_W = 64;
  localparam int STRB_W     = AXI_DATA_W / 8;
  localparam int ADDR_W     = 32;
  localparam int LEN_W      = 10;  // beats
  localparam int ID_W       = 4;
  localparam int MAX_BURST  = 16;  // axi3 limit
  localparam int BEAT_BYTES = 8;

  // ==================================================
  // type codes and memory map
  // ==================================================
  localparam logic [3:0]        TYPE_FLGOFM = 4'h1;
  localparam logic [3:0]        TYPE_OFM    = 4'h2;
  localparam logic [ADDR_W-1:0] FLGOFM_BASE = 32'h0805_0000;
  localparam logic [ADDR_W-1:0] OFM_BASE    = 32'h0804_8000;
  localparam int                FLGOFM_WORDS = 4;   // 96-bit words per transfer
  localparam int                OFM_WORDS    = 16;

  typedef struct packed {
    logic [63:0] rsvd_hi;
    logic [3:0]  type_code;  // bits 31:28
    logic [27:0] rsvd_lo;
  } cfg_word_t;

  // one sampled bus word, config or payload
  typedef union packed {
    cfg_word_t          cfg;
    logic [BUS_W-1:0]   raw;
  } bus_word_u;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  beats;
    logic [3:0]        type_code;
  } wr_cmd_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [3:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
    logic [1:0]        lock;
    logic [3:0]        cache;
    logic [2:0]        prot;
    logic [3:0]        qos;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [STRB_W-1:0]     strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } axi_b_t;

endpackage

// File: mcw_top.sv
`timescale 1ns/1ps
module mcw_top import mcw_pkg::*; #(
  parameter int CAP_DEPTH = 4,
  parameter int OUT_DEPTH = 32,
  parameter int AXI_ID    = 0
) (
  input  logic             clk,
  input  logic             reset,
  // chip side
  input  logic             config_req,
  input  logic [BUS_W-1:0] spi_data,
  output logic             spi_cs_n,
  // axi write
  output axi_aw_t          aw,
  output logic             aw_valid,
  input  logic             aw_ready,
  output axi_w_t           w,
  output logic             w_valid,
  input  logic             w_ready,
  input  axi_b_t           b,
  input  logic             b_valid,
  output logic             b_ready,
  // status
  output logic             wr_done,
  output logic             wr_error
);
  logic                           cfg_valid;
  bus_word_u                      cfg;
  logic                           cmd_accept;
  logic                           cmd_reject;
  logic                           cmd_free;
  logic [LEN_W-1:0]               words;
  wr_cmd_t                        cmd;
  logic                           cmd_valid;
  logic                           cmd_take;
  logic                           cmd_done;
  logic                           cap_push;
  logic [BUS_W-1:0]               cap_data;
  logic [$clog2(CAP_DEPTH+1)-1:0] cap_count;
  logic                           cap_empty;
  logic [BUS_W-1:0]               cap_out;
  logic                           cap_pop;
  logic                           beat_push;
  logic [AXI_DATA_W-1:0]          beat_in;
  logic                           beat_full;
  logic                           beat_empty;
  logic [AXI_DATA_W-1:0]          beat_data;
  logic                           beat_pop;

  chip_link #(.CAP_DEPTH(CAP_DEPTH)) u_chip_link (
    .clk(clk), .reset(reset), .config_req(config_req), .spi_data(spi_data),
    .cmd_accept(cmd_accept), .cmd_reject(cmd_reject), .cmd_free(cmd_free),
    .words(words), .cap_count(cap_count), .spi_cs_n(spi_cs_n),
    .cfg_valid(cfg_valid), .cfg(cfg), .cap_push(cap_push), .cap_data(cap_data)
  );

  write_cmd_gen u_write_cmd_gen (
    .clk(clk), .reset(reset), .cfg_valid(cfg_valid), .cfg(cfg),
    .cmd_take(cmd_take), .cmd_done(cmd_done), .cmd_accept(cmd_accept),
    .cmd_reject(cmd_reject), .cmd_free(cmd_free), .words(words),
    .cmd(cmd), .cmd_valid(cmd_valid)
  );

  sync_fifo #(.WIDTH(BUS_W), .DEPTH(CAP_DEPTH)) cap_fifo (
    .clk(clk), .reset(reset), .push(cap_push), .data_in(cap_data), .pop(cap_pop),
    .full(), .empty(cap_empty), .data_out(cap_out), .count(cap_count)
  );

  word_packer u_word_packer (
    .clk(clk), .reset(reset), .in_valid(!cap_empty), .in_data(cap_out),
    .out_full(beat_full), .in_pop(cap_pop), .out_push(beat_push), .out_data(beat_in)
  );

  sync_fifo #(.WIDTH(AXI_DATA_W), .DEPTH(OUT_DEPTH)) beat_fifo (
    .clk(clk), .reset(reset), .push(beat_push), .data_in(beat_in), .pop(beat_pop),
    .full(beat_full), .empty(beat_empty), .data_out(beat_data), .count()
  );

  axi_write_master #(.AXI_ID(AXI_ID)) u_axi_write_master (
    .clk(clk), .reset(reset), .cmd(cmd), .cmd_valid(cmd_valid),
    .beat_empty(beat_empty), .beat_data(beat_data), .aw_ready(aw_ready),
    .w_ready(w_ready), .b(b), .b_valid(b_valid), .cmd_take(cmd_take),
    .cmd_done(cmd_done), .beat_pop(beat_pop), .aw(aw), .aw_valid(aw_valid),
    .w(w), .w_valid(w_valid), .b_ready(b_ready), .wr_done(wr_done),
    .wr_error(wr_error)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --top-module tb_top -f verilog.f -o tb_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0

// File: sync_fifo.sv
`timescale 1ns/1ps
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push,
  input  logic [WIDTH-1:0]               data_in,
  input  logic                           pop,
  output logic                           full,
  output logic                           empty,
  output logic [WIDTH-1:0]               data_out,
  output logic [$clog2(DEPTH+1)-1:0]     count
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;   // overflow dropped
  assign do_pop   = pop && !empty;
  assign data_out = mem[rd_ptr];     // fall-through head

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= data_in;
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: tb_axi_slave.sv
`timescale 1ns/1ps
module tb_axi_slave import mcw_pkg::*; #(
  parameter logic [ADDR_W-1:0] MEM_BASE  = 32'h0804_8000,
  parameter int                MEM_BEATS = 8192   // covers both maps
) (
  input  logic                  clk,
  input  logic                  reset,
  input  axi_aw_t               aw,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_w_t                w,
  input  logic                  w_valid,
  output logic                  w_ready,
  output axi_b_t                b,
  output logic                  b_valid,
  input  logic                  b_ready,
  input  logic                  stall_en,
  input  int                    stall_pct,
  input  int                    err_burst,    // burst number that gets SLVERR
  input  logic [ADDR_W-1:0]     peek_addr,
  output logic [AXI_DATA_W-1:0] peek_data
);
  localparam int IDX_W = $clog2(MEM_BEATS);

  logic [AXI_DATA_W-1:0] mem [MEM_BEATS];
  logic [ADDR_W-1:0]     fill_addr;
  logic [ADDR_W-1:0]     wr_addr;
  logic [ID_W-1:0]       wr_id;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic                  b_pend;
  axi_aw_t               aw_s;
  axi_w_t                w_s;
  int                    bursts;

  function automatic logic [IDX_W-1:0] beat_index(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] off;
    off = addr - MEM_BASE;
    return off[IDX_W+2:3];
  endfunction

  function automatic logic ready_draw();
    if (!stall_en) return 1'b1;
    return ($urandom % 100) >= stall_pct;
  endfunction

  assign peek_data = mem[beat_index(peek_addr)];

  // ==================================================
  // memory fill, unique per address
  // ==================================================
  initial begin
    for (int i = 0; i < MEM_BEATS; i++) begin
      fill_addr = MEM_BASE + ADDR_W'(i * BEAT_BYTES);
      mem[i] = {~fill_addr, fill_addr};
    end
  end

  // ==================================================
  // channel handling
  // ==================================================
  initial begin
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    b_valid  = 1'b0;
    b        = '0;
    b_pend   = 1'b0;
    bursts   = 0;
    forever begin
      @(negedge clk);               // handshakes settle before the next edge
      aw_hs = aw_valid && aw_ready;
      w_hs  = w_valid && w_ready;
      b_hs  = b_valid && b_ready;
      aw_s  = aw;
      w_s   = w;
      @(posedge clk);
      #1;
      if (!reset) begin
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        b_pend   = 1'b0;
      end else begin
        if (aw_hs) begin
          wr_addr = aw_s.addr;
          wr_id   = aw_s.id;
        end
        if (w_hs) begin
          mem[beat_index(wr_addr)] = w_s.data;
          wr_addr = wr_addr + ADDR_W'(BEAT_BYTES);
          if (w_s.last) b_pend = 1'b1;
        end
        if (b_hs) b_valid = 1'b0;
        if (b_pend && !b_valid) begin
          b_valid = 1'b1;
          b.id    = wr_id;
          b.resp  = (bursts == err_burst) ? 2'b10 : 2'b00;  // SLVERR or OKAY
          bursts++;
          b_pend  = 1'b0;
        end
        aw_ready = ready_draw();
        w_ready  = ready_draw();
      end
    end
  end

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps
module tb_clock #(
  parameter int HALF_NS      = 2,   // 4 ns period
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);
  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

  // active low, released just after an edge
  initial begin
    reset = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b1;
  end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps
module tb_top import mcw_pkg::*; ();
  localparam int SEED           = 93;
  localparam int TIMEOUT_CYCLES = 20000;  // well above the longest test sequence
  localparam int WAIT_LIMIT     = 2000;
  localparam int STALL_PCT      = 40;
  localparam int WORD_BYTES     = BUS_W / 8;

  logic                  clk;
  logic                  reset;
  logic                  config_req;
  logic [BUS_W-1:0]      spi_data;
  logic                  spi_cs_n;
  axi_aw_t               aw;
  logic                  aw_valid;
  logic                  aw_ready;
  axi_w_t                w;
  logic                  w_valid;
  logic                  w_ready;
  axi_b_t                b;
  logic                  b_valid;
  logic                  b_ready;
  logic                  wr_done;
  logic                  wr_error;
  logic                  stall_en;
  int                    err_burst;
  logic [ADDR_W-1:0]     peek_addr;
  logic [AXI_DATA_W-1:0] peek_data;

  int                    errors = 0;
  int                    checks = 0;
  int                    tests = 0;
  int                    cycles = 0;
  int                    done_cnt = 0;
  int                    cs_low_cnt = 0;
  int                    beat_in_burst = 0;
  int                    flg_idx = 0;
  int                    ofm_idx = 0;
  logic                  last_err = 1'b0;
  logic [ADDR_W-1:0]     xfer_addr;
  logic [ADDR_W-1:0]     aw_addr_q[$];
  logic [3:0]            aw_len_q[$];
  logic [ADDR_W-1:0]     exp_addr_q[$];
  logic [AXI_DATA_W-1:0] exp_data_q[$];

  tb_clock u_clock (.clk(clk), .reset(reset));

  mcw_top #(.CAP_DEPTH(4), .OUT_DEPTH(32), .AXI_ID(0)) dut (
    .clk(clk), .reset(reset), .config_req(config_req), .spi_data(spi_data),
    .spi_cs_n(spi_cs_n), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready), .b(b), .b_valid(b_valid),
    .b_ready(b_ready), .wr_done(wr_done), .wr_error(wr_error)
  );

  tb_axi_slave u_slave (
    .clk(clk), .reset(reset), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w(w), .w_valid(w_valid), .w_ready(w_ready), .b(b), .b_valid(b_valid),
    .b_ready(b_ready), .stall_en(stall_en), .stall_pct(STALL_PCT),
    .err_burst(err_burst), .peek_addr(peek_addr), .peek_data(peek_data)
  );

  // ==================================================
  // checking helpers
  // ==================================================
  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at t=%0t: %s", $time, what);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d (%s) finished, %0d errors so far", tests, name, errors);
  endtask

  function automatic int burst_count(input int beats);
    return (beats + MAX_BURST - 1) / MAX_BURST;
  endfunction

  // bus monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (reset) begin
      if (aw_valid && aw_ready) begin
        aw_addr_q.push_back(aw.addr);
        aw_len_q.push_back(aw.len);
        check("aw.id", aw.id, 0);
        check("aw.size", aw.size, 3);        // 8-byte beats
        check("aw.burst", aw.burst, 2'b01);  // INCR
        beat_in_burst = 0;
      end
      if (w_valid && w_ready) begin
        check("w.strb", w.strb, {STRB_W{1'b1}});
        check("w.last", w.last, beat_in_burst == int'(aw_len_q[$]));
        beat_in_burst++;
      end
      if (b_valid) check("b_ready", b_ready, 1'b1);
      if (!spi_cs_n) cs_low_cnt++;
      if (wr_done) begin
        done_cnt++;
        last_err = wr_error;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // ==================================================
  // chip model
  // ==================================================
  task automatic chip_transfer(input logic [3:0] tcode, input int nwords);
    bus_word_u          cw;
    logic [BUS_W-1:0]   word;
    logic [BUS_W-1:0]   wq[$];
    logic [2*BUS_W-1:0] pair;
    logic [ADDR_W-1:0]  addr;
    logic               pend;
    int                 guard;
    int                 cs0;
    pend  = 1'b0;
    guard = 0;
    cs0   = cs_low_cnt;
    cw.raw = {$urandom(), $urandom(), $urandom()};
    cw.cfg.type_code = tcode;
    @(posedge clk);
    #1;
    spi_data   = cw.raw;   // held until the first select
    config_req = 1'b1;
    while (wq.size() < nwords && guard < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      guard++;
      if (pend) begin
        word = {$urandom(), $urandom(), $urandom()};
        spi_data = word;
        wq.push_back(word);
      end
      pend = !spi_cs_n;    // next edge asks for a word
    end
    if (wq.size() < nwords) report_failure($sformatf("chip saw %0d of %0d selects",
                                                     wq.size(), nwords));
    @(posedge clk);
    #1;
    config_req = 1'b0;
    repeat (3) @(posedge clk);
    check("spi_cs_n low edges", cs_low_cnt - cs0, nwords);
    // expected image, 2 words give 3 beats lowest bits first
    if (tcode == TYPE_FLGOFM) begin
      addr = FLGOFM_BASE + ADDR_W'(flg_idx * FLGOFM_WORDS * WORD_BYTES);
      flg_idx++;
    end else begin
      addr = OFM_BASE + ADDR_W'(ofm_idx * OFM_WORDS * WORD_BYTES);
      ofm_idx++;
    end
    xfer_addr = addr;
    for (int i = 0; i + 1 < wq.size(); i += 2) begin
      pair = {wq[i+1], wq[i]};
      for (int k = 0; k < 3; k++) begin
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(pair[k*AXI_DATA_W +: AXI_DATA_W]);
        addr = addr + ADDR_W'(BEAT_BYTES);
      end
    end
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    while (done_cnt < target && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (done_cnt < target) report_failure("wr_done never arrived");
    @(posedge clk);
    #1;
  endtask

  task automatic verify_memory();
    logic [ADDR_W-1:0] a;
    while (exp_addr_q.size() > 0) begin
      a = exp_addr_q.pop_front();
      peek_addr = a;
      #1;
      check($sformatf("mem[%h]", a), peek_data, exp_data_q.pop_front());
    end
  endtask

  task automatic check_bursts(input int first, input logic [ADDR_W-1:0] start,
                              input int beats);
    logic [ADDR_W-1:0] addr;
    int                left;
    int                n;
    int                k;
    addr = start;
    left = beats;
    k    = first;
    while (left > 0) begin
      n = (left > MAX_BURST) ? MAX_BURST : left;
      if (k < aw_addr_q.size()) begin
        check("aw.addr", aw_addr_q[k], addr);
        check("aw.len", aw_len_q[k], n - 1);
      end else begin
        report_failure($sformatf("burst at %h never got an AW handshake", addr));
      end
      addr = addr + ADDR_W'(MAX_BURST * BEAT_BYTES);
      left = left - n;
      k++;
    end
  endtask

  task automatic run_transfer(input logic [3:0] tcode, input int nwords, input logic exp_err);
    int aw0;
    int d0;
    int beats;
    aw0   = aw_addr_q.size();
    d0    = done_cnt;
    beats = nwords * 3 / 2;
    chip_transfer(tcode, nwords);
    wait_done(d0 + 1);
    check("wr_done pulses", done_cnt - d0, 1);
    check("wr_error", last_err, exp_err);
    check("aw handshakes", aw_addr_q.size() - aw0, burst_count(beats));
    check_bursts(aw0, xfer_addr, beats);
    verify_memory();
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic test_reset_state();
    check("spi_cs_n", spi_cs_n, 1'b1);
    check("aw_valid", aw_valid, 1'b0);
    check("w_valid", w_valid, 1'b0);
    check("wr_done", wr_done, 1'b0);
    finish_test("reset state");
  endtask

  task automatic test_ofm_pair();
    int aw0;
    aw0 = aw_addr_q.size();
    run_transfer(TYPE_OFM, OFM_WORDS, 1'b0);
    run_transfer(TYPE_OFM, OFM_WORDS, 1'b0);
    if (aw_addr_q.size() >= aw0 + 3) begin
      check("second burst offset", aw_addr_q[aw0+1] - aw_addr_q[aw0], 128);
      check("second transfer offset", aw_addr_q[aw0+2] - aw_addr_q[aw0], 192);
    end
    finish_test("output map pair");
  endtask

  task automatic test_stalls();
    logic [ADDR_W-1:0] a1;
    int                aw0;
    int                d0;
    aw0 = aw_addr_q.size();
    d0  = done_cnt;
    stall_en = 1'b1;
    chip_transfer(TYPE_FLGOFM, FLGOFM_WORDS);
    a1 = xfer_addr;
    chip_transfer(TYPE_OFM, OFM_WORDS);   // waits on the first command
    wait_done(d0 + 2);
    stall_en = 1'b0;
    check("wr_done pulses", done_cnt - d0, 2);
    check("aw handshakes", aw_addr_q.size() - aw0, 3);
    check_bursts(aw0, a1, FLGOFM_WORDS * 3 / 2);
    check_bursts(aw0 + 1, xfer_addr, OFM_WORDS * 3 / 2);
    verify_memory();
    finish_test("stalls back to back");
  endtask

  task automatic test_bad_type();
    bus_word_u cw;
    int        aw0;
    int        cs0;
    int        d0;
    aw0 = aw_addr_q.size();
    cs0 = cs_low_cnt;
    d0  = done_cnt;
    cw.raw = {$urandom(), $urandom(), $urandom()};
    cw.cfg.type_code = 4'h7;
    @(posedge clk);
    #1;
    spi_data   = cw.raw;
    config_req = 1'b1;
    repeat (40) @(posedge clk);
    #1;
    config_req = 1'b0;
    repeat (3) @(posedge clk);
    check("spi_cs_n low edges", cs_low_cnt - cs0, 0);
    check("aw handshakes", aw_addr_q.size() - aw0, 0);
    check("wr_done pulses", done_cnt - d0, 0);
    run_transfer(TYPE_FLGOFM, FLGOFM_WORDS, 1'b0);
    finish_test("unknown type code");
  endtask

  task automatic test_slverr();
    err_burst = aw_addr_q.size() + 1;   // second burst of the next command
    run_transfer(TYPE_OFM, OFM_WORDS, 1'b1);
    err_burst = -1;
    finish_test("slave error");
  endtask

  initial begin
    config_req = 1'b0;
    spi_data   = '0;
    stall_en   = 1'b0;
    err_burst  = -1;
    peek_addr  = FLGOFM_BASE;
    void'($urandom(SEED));
    wait (reset === 1'b1);
    @(posedge clk);
    #1;
    test_reset_state();
    run_transfer(TYPE_FLGOFM, FLGOFM_WORDS, 1'b0);
    finish_test("flag output map");
    test_ofm_pair();
    test_stalls();
    test_bad_type();
    test_slverr();
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
mcw_pkg.sv
sync_fifo.sv
chip_link.sv
write_cmd_gen.sv
word_packer.sv
axi_write_master.sv
mcw_top.sv
tb_clock.sv
tb_axi_slave.sv
tb_top.sv

// File: word_packer.sv
`timescale 1ns/1ps
module word_packer import mcw_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  logic [BUS_W-1:0]      in_data,
  input  logic                  out_full,
  output logic                  in_pop,
  output logic                  out_push,
  output logic [AXI_DATA_W-1:0] out_data
);
  localparam int RES_W  = 2 * AXI_DATA_W;       // 128

  logic [RES_W-1:0] res;    // residue, lowest bits leave first
  logic [2:0]       slots;  // valid 32-bit slots in res

  // a new word fits only when at most one slot is held
  assign in_pop   = in_valid && (slots <= 3'd1);
  assign out_push = (slots >= 3'd2) && !out_full;
  assign out_data = res[AXI_DATA_W-1:0];

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      slots <= '0;
    end else if (in_pop) begin
      slots <= slots + 3'd3;
    end else if (out_push) begin
      slots <= slots - 3'd2;
    end
  end

  always_ff @(posedge clk) begin
    if (in_pop) begin
      if (slots == 3'd0) res[BUS_W-1:0] <= in_data;
      else               res[RES_W-1 -: BUS_W] <= in_data;  // above one held slot
    end else if (out_push) begin
      res[AXI_DATA_W-1:0] <= res[RES_W-1:AXI_DATA_W];
    end
  end

endmodule

// File: write_cmd_gen.sv
`timescale 1ns/1ps
module write_cmd_gen import mcw_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             cfg_valid,
  input  bus_word_u        cfg,
  input  logic             cmd_take,
  input  logic             cmd_done,
  output logic             cmd_accept,
  output logic             cmd_reject,
  output logic             cmd_free,
  output logic [LEN_W-1:0] words,
  output wr_cmd_t          cmd,
  output logic             cmd_valid
);
  localparam int WORD_BYTES = BUS_W / 8;  // 12
  localparam int IDX_W      = 16;

  logic [IDX_W-1:0]  flg_idx;
  logic [IDX_W-1:0]  ofm_idx;
  logic              busy;
  logic              known;
  logic [LEN_W-1:0]  dec_words;
  logic [ADDR_W-1:0] dec_addr;

  always_comb begin
    known     = 1'b1;
    dec_words = LEN_W'(OFM_WORDS);
    dec_addr  = OFM_BASE + ADDR_W'(ofm_idx) * ADDR_W'(OFM_WORDS * WORD_BYTES);
    case (cfg.cfg.type_code)
      TYPE_FLGOFM: begin
        dec_words = LEN_W'(FLGOFM_WORDS);
        dec_addr  = FLGOFM_BASE + ADDR_W'(flg_idx) * ADDR_W'(FLGOFM_WORDS * WORD_BYTES);
      end
      TYPE_OFM: known = 1'b1;
      default:  known = 1'b0;
    endcase
  end

  assign cmd_free = !busy;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      cmd_accept <= 1'b0;
      cmd_reject <= 1'b0;
      cmd_valid  <= 1'b0;
      busy       <= 1'b0;
      words      <= '0;
      flg_idx    <= '0;
      ofm_idx    <= '0;
    end else begin
      cmd_accept <= cfg_valid && known;
      cmd_reject <= cfg_valid && !known;
      if (cmd_take) cmd_valid <= 1'b0;
      if (cmd_done) busy <= 1'b0;   // last B seen
      if (cfg_valid && known) begin
        cmd_valid <= 1'b1;
        busy      <= 1'b1;
        words     <= dec_words;
        if (cfg.cfg.type_code == TYPE_FLGOFM) flg_idx <= flg_idx + 1'b1;
        else                                  ofm_idx <= ofm_idx + 1'b1;
      end
    end
  end

  // 3 beats per 2 words
  always_ff @(posedge clk) begin
    if (cfg_valid && known) begin
      cmd.addr      <= dec_addr;
      cmd.beats     <= LEN_W'((dec_words * 3) >> 1);
      cmd.type_code <= cfg.cfg.type_code;
    end
  end

endmodule
